// File: Bender.yml
package:
  name: fetch_unit

sources:
  - hdl/fetch_pkg.sv
  - hdl/fetch_pc_gen.sv
  - hdl/fetch_icache.sv
  - hdl/fetch_refill.sv
  - hdl/fetch_out_stage.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - tests/fetch_tb.sv

// File: compile.f
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_icache.sv
hdl/fetch_refill.sv
hdl/fetch_out_stage.sv
hdl/fetch_top.sv
tests/fetch_tb.sv

// File: hdl/fetch_icache.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_icache #(
  parameter int LINES = 8
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          pc_valid_i,
  input  wire  [31:0]                  pc_i,
  input  wire                          stall_i,
  output logic                         hit_o,
  output logic [31:0]                  hit_inst_o,
  output fetch_pkg::refill_req_t       refill_req_o,
  input  wire                          refill_busy_i,
  input  wire                          beat_valid_i,
  input  wire fetch_pkg::refill_beat_t beat_i,
  input  wire                          cancel_i
);
  import fetch_pkg::*;

  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = 29 - IDX_W;

  // two words per line
  logic [31:0]      data_mem [LINES][2];
  logic [TAG_W-1:0] tag_mem [LINES];
  logic [LINES-1:0] valid_q;

  // refill bookkeeping
  logic             wait_q;
  logic             fence_q;
  logic             discard_q;
  logic [28:0]      fill_line_q;

  logic [TAG_W-1:0] pc_tag;
  logic [IDX_W-1:0] pc_idx;
  logic             pc_word;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic             lookup_hit;
  logic             last_beat;
  logic             bypass;
  logic [31:0]      bypass_word;
  logic             fence_now;
  logic             start;

  assign pc_word  = pc_i[2];
  assign pc_idx   = pc_i[3 +: IDX_W];
  assign pc_tag   = pc_i[31 -: TAG_W];
  assign fill_idx = fill_line_q[IDX_W-1:0];
  assign fill_tag = fill_line_q[28 -: TAG_W];

  assign lookup_hit = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag);
  assign last_beat  = beat_valid_i && beat_i.last;

  // word 0 is already in the array when the last beat shows up
  assign bypass = last_beat && !discard_q && (pc_i[31:3] == fill_line_q);
  assign bypass_word = (pc_word == beat_i.word_sel) ? beat_i.data
                                                    : data_mem[fill_idx][pc_word];

  // array lookups are held off until the pending fill lands
  assign hit_o = pc_valid_i && !cancel_i && ((lookup_hit && !wait_q) || bypass);
  assign hit_inst_o = bypass ? bypass_word : data_mem[pc_idx][pc_word];

  // one refill at a time, and none while decode is backed up
  assign start = pc_valid_i && !cancel_i && !lookup_hit && !wait_q && !stall_i;

  assign refill_req_o.line_addr = pc_i[31:3];
  assign refill_req_o.start     = start;

  assign fence_now = fence_q || (beat_i.data == FENCE_I_WORD);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q   <= '0;
      wait_q    <= 1'b0;
      fence_q   <= 1'b0;
      discard_q <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        wait_q    <= 1'b1;
        fence_q   <= 1'b0;
        discard_q <= 1'b0;
      end
      else if (cancel_i && wait_q)
      begin
        // fill still completes, only the forwarded word is dropped
        discard_q <= 1'b1;
      end

      if (beat_valid_i)
      begin
        if (beat_i.last)
        begin
          wait_q <= 1'b0;
          // fence.i anywhere in the line leaves the whole cache empty,
          // including the line just written
          if (fence_now)
          begin
            valid_q <= '0;
          end
          else
          begin
            valid_q[fill_idx] <= 1'b1;
          end
        end
        else if (fence_now)
        begin
          fence_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      fill_line_q <= pc_i[31:3];
    end
    if (beat_valid_i)
    begin
      data_mem[fill_idx][beat_i.word_sel] <= beat_i.data;
      if (beat_i.last)
      begin
        tag_mem[fill_idx] <= fill_tag;
      end
    end
  end

  // the refill master must be idle whenever the cache is not waiting
  refill_start_idle: assert property (@(posedge clk) disable iff (rst)
    refill_req_o.start |-> !refill_busy_i);

  // during a refill only the bypassed last beat may report a hit
  hit_only_on_bypass: assert property (@(posedge clk) disable iff (rst)
    (hit_o && refill_busy_i) |-> (beat_valid_i && beat_i.last));

endmodule

`default_nettype wire

// File: hdl/fetch_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_out_stage (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     hit_i,
  input  wire  [31:0]             pc_i,
  input  wire  [31:0]             inst_i,
  input  wire                     flush_i,
  input  wire                     out_ready_i,
  output logic                    out_valid_o,
  output fetch_pkg::fetch_out_t   out_o,
  output logic                    accept_o,
  output logic                    stall_o
);
  import fetch_pkg::*;

  logic       valid_q;
  fetch_out_t data_q;
  logic [6:0] opcode;
  logic       is_cti;

  assign opcode = inst_i[6:0];
  assign is_cti = (opcode == OPC_JAL) || (opcode == OPC_JALR) || (opcode == OPC_BRANCH);

  // full and not draining
  assign stall_o = valid_q && !out_ready_i;

  // capture when empty or the held item leaves this cycle
  assign accept_o = hit_i && !flush_i && (!valid_q || out_ready_i);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (accept_o)
    begin
      valid_q <= 1'b1;
    end
    else if (out_ready_i)
    begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept_o)
    begin
      data_q.pc     <= pc_i;
      data_q.inst   <= inst_i;
      data_q.is_cti <= is_cti;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = data_q;

  hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=> $stable(out_o));

endmodule

`default_nettype wire

// File: hdl/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         redirect_i,
  input  wire  [31:0] redirect_pc_i,
  input  wire         accept_i,
  output logic        pc_valid_o,
  output logic [31:0] pc_o
);

  logic [31:0] pc_q;
  logic [31:0] pc_next;

  // redirect wins over a sequential step
  always_comb
  begin
    pc_next = pc_q;
    if (redirect_i)
    begin
      pc_next = redirect_pc_i;
    end
    else if (accept_i)
    begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
    end
    else
    begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // no lookup in the redirect cycle, the pc is about to change
  assign pc_valid_o = !redirect_i;

  redirect_aligned: assert property (@(posedge clk) disable iff (rst)
    redirect_i |-> (redirect_pc_i[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // one fetched instruction toward decode
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    // jal, jalr or branch
    logic        is_cti;
  } fetch_out_t;

  // line refill request from cache to refill master
  typedef struct packed {
    // byte address bits 31:3
    logic [28:0] line_addr;
    logic        start;
  } refill_req_t;

  // one refill word returned to the cache
  typedef struct packed {
    logic [31:0] data;
    logic        word_sel;
    logic        last;
  } refill_beat_t;

  // seeing this in refill data flushes the whole cache
  localparam logic [31:0] FENCE_I_WORD = 32'h0000100f;

  // major opcodes that change control flow
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

// File: hdl/fetch_refill.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_refill (
  input  wire                         clk,
  input  wire                         rst,
  input  wire fetch_pkg::refill_req_t req_i,
  output logic                        busy_o,
  output logic                        mem_req_o,
  output logic [31:0]                 mem_addr_o,
  input  wire                         mem_rvalid_i,
  input  wire  [31:0]                 mem_rdata_i,
  output logic                        beat_valid_o,
  output fetch_pkg::refill_beat_t     beat_o
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WORD0 = 2'd1;
  localparam logic [1:0] ST_WORD1 = 2'd2;

  logic [1:0]  state_q;
  logic        req_q;
  logic [28:0] line_q;
  logic        word;

  assign word = (state_q == ST_WORD1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ST_IDLE;
      req_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
          if (req_i.start)
          begin
            state_q <= ST_WORD0;
            req_q   <= 1'b1;
          end
        ST_WORD0:
          if (mem_rvalid_i)
          begin
            // request drops for a cycle before word 1 is asked for
            state_q <= ST_WORD1;
            req_q   <= 1'b0;
          end
        ST_WORD1:
          if (!req_q)
          begin
            req_q <= 1'b1;
          end
          else if (mem_rvalid_i)
          begin
            state_q <= ST_IDLE;
            req_q   <= 1'b0;
          end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == ST_IDLE && req_i.start)
    begin
      line_q <= req_i.line_addr;
    end
  end

  assign busy_o     = (state_q != ST_IDLE);
  assign mem_req_o  = req_q;
  assign mem_addr_o = {line_q, word, 2'b00};

  // responses are forwarded in the cycle they arrive
  assign beat_valid_o    = req_q && mem_rvalid_i;
  assign beat_o.data     = mem_rdata_i;
  assign beat_o.word_sel = word;
  assign beat_o.last     = word;

  addr_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req_o && !mem_rvalid_i) |=> (mem_req_o && $stable(mem_addr_o)));

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter int          LINES    = 8,
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   redirect_i,
  input  wire  [31:0]           redirect_pc_i,
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output fetch_pkg::fetch_out_t out_o,
  output logic                  mem_req_o,
  output logic [31:0]           mem_addr_o,
  input  wire                   mem_rvalid_i,
  input  wire  [31:0]           mem_rdata_i
);
  import fetch_pkg::*;

  logic         pc_valid;
  logic [31:0]  pc;
  logic         hit;
  logic [31:0]  hit_inst;
  logic         accept;
  logic         stall;
  refill_req_t  refill_req;
  logic         refill_busy;
  logic         beat_valid;
  refill_beat_t beat;

  fetch_pc_gen #(
    .RESET_PC (RESET_PC)
  ) pc_gen0 (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .accept_i      (accept),
    .pc_valid_o    (pc_valid),
    .pc_o          (pc)
  );

  fetch_icache #(
    .LINES (LINES)
  ) icache0 (
    .clk           (clk),
    .rst           (rst),
    .pc_valid_i    (pc_valid),
    .pc_i          (pc),
    .stall_i       (stall),
    .hit_o         (hit),
    .hit_inst_o    (hit_inst),
    .refill_req_o  (refill_req),
    .refill_busy_i (refill_busy),
    .beat_valid_i  (beat_valid),
    .beat_i        (beat),
    .cancel_i      (redirect_i)
  );

  fetch_refill refill0 (
    .clk          (clk),
    .rst          (rst),
    .req_i        (refill_req),
    .busy_o       (refill_busy),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .beat_valid_o (beat_valid),
    .beat_o       (beat)
  );

  // redirect also drops whatever decode has not yet taken
  fetch_out_stage out0 (
    .clk         (clk),
    .rst         (rst),
    .hit_i       (hit),
    .pc_i        (pc),
    .inst_i      (hit_inst),
    .flush_i     (redirect_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .accept_o    (accept),
    .stall_o     (stall)
  );

endmodule

`default_nettype wire

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int          LINES    = 8;
  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam logic [31:0] FENCE_I  = 32'h0000100f;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  redirect_i;
  logic [31:0]           redirect_pc_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  fetch_pkg::fetch_out_t out_o;
  logic                  mem_req_o;
  logic [31:0]           mem_addr_o;
  logic                  mem_rvalid_i;
  logic [31:0]           mem_rdata_i;

  logic [31:0]           rng_state = 32'hcfe96003;
  // shadow of the cache, full line address per entry
  logic                  sh_valid [LINES];
  logic [28:0]           sh_line [LINES];
  logic [28:0]           last_fill = '1;
  logic [28:0]           fill_line;
  logic                  fill_word = 1'b0;
  logic                  fill_fence = 1'b0;
  logic                  pending = 1'b0;
  int                    wait_cnt;
  logic [31:0]           read_addr;
  logic [31:0]           exp_pc = RESET_PC;
  logic                  held = 1'b0;
  fetch_pkg::fetch_out_t held_item;
  int                    data_errors = 0;
  int                    bus_errors = 0;
  int                    timeouts = 0;
  int                    items = 0;
  int                    idle = 0;

  fetch_top #(
    .LINES    (LINES),
    .RESET_PC (RESET_PC)
  ) dut0 (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_o         (out_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int percent();
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16] % 100);
  endfunction

  // fixed pseudo random program, a pure function of the byte address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] h;
    int          sel;
    h   = (addr ^ 32'h5bd1e995) * 32'd1664525 + 32'd1013904223;
    h   = (h ^ (h >> 15)) * 32'd1664525 + 32'd1013904223;
    sel = int'(h[31:16] % 100);
    if (sel < 3)
      return FENCE_I;
    else if (sel < 13)
      return {h[31:7], 7'b1100011};
    else if (sel < 16)
      return {h[31:7], 7'b1101111};
    return h;
  endfunction

  task automatic data_error(input string msg);
    data_errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic bus_error(input string msg);
    bus_errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic answer_read();
    int idx;
    idx          = int'(fill_line % LINES);
    pending      = 1'b0;
    mem_rvalid_i = 1'b1;
    mem_rdata_i  = mem_word(read_addr);
    if (mem_rdata_i == FENCE_I)
      fill_fence = 1'b1;
    if (fill_word)
    begin
      // end of the line, fence.i empties the whole cache
      if (fill_fence)
      begin
        foreach (sh_valid[i])
          sh_valid[i] = 1'b0;
      end
      else
      begin
        sh_valid[idx] = 1'b1;
        sh_line[idx]  = fill_line;
      end
      last_fill  = fill_line;
      fill_fence = 1'b0;
    end
    fill_word = !fill_word;
  endtask

  // memory side, once per falling edge
  task automatic serve_memory();
    logic [28:0] line;
    if (mem_rvalid_i)
    begin
      mem_rvalid_i = 1'b0;
      if (mem_req_o)
        bus_error("mem_req_o still high after its response");
    end
    else
    begin
      line = mem_addr_o[31:3];
      if (!pending && mem_req_o)
      begin
        pending   = 1'b1;
        read_addr = mem_addr_o;
        wait_cnt  = percent() % 6;
        if (!fill_word)
        begin
          if (mem_addr_o[2])
            bus_error("refill did not start with word 0");
          if (sh_valid[line % LINES] && sh_line[line % LINES] == line)
            bus_error($sformatf("refill of cached line at %h", mem_addr_o));
          fill_line = line;
        end
        else if (mem_addr_o != {fill_line, 3'b100})
          bus_error($sformatf("second read at %h is not word 1 of the line", mem_addr_o));
      end
      else if (pending && (!mem_req_o || mem_addr_o != read_addr))
        bus_error("request dropped or address changed before the response");
      if (pending && wait_cnt > 0)
        wait_cnt--;
      else if (pending)
        answer_read();
    end
  endtask

  // decode side, once per falling edge
  task automatic drive_decode();
    logic [31:0] r;
    logic [28:0] line;
    logic [6:0]  opc;
    if (held && (!out_valid_o || out_o != held_item))
      data_error("output changed under back-pressure");
    out_ready_i = (percent() < 70);
    // first fetch after reset always comes from the reset pc
    redirect_i  = !redirect_i && (items > 0) && (percent() < 5);
    if (out_valid_o && out_ready_i)
    begin
      line = out_o.pc[31:3];
      opc  = out_o.inst[6:0];
      if (out_o.pc != exp_pc)
        data_error($sformatf("pc %h, expected %h", out_o.pc, exp_pc));
      if (out_o.inst != mem_word(out_o.pc))
        data_error($sformatf("inst %h at pc %h", out_o.inst, out_o.pc));
      if (out_o.is_cti != (opc == 7'b1101111 || opc == 7'b1100111 || opc == 7'b1100011))
        data_error($sformatf("is_cti wrong for inst %h", out_o.inst));
      if (!(sh_valid[line % LINES] && sh_line[line % LINES] == line) && line != last_fill)
        data_error($sformatf("pc %h served from a line not refilled", out_o.pc));
      exp_pc = exp_pc + 32'd4;
      items++;
      idle = 0;
    end
    else
      idle++;
    if (redirect_i)
    begin
      r             = next_rand();
      redirect_pc_i = {22'd0, r[23:16], 2'b00};
      exp_pc        = redirect_pc_i;
    end
    held      = out_valid_o && !out_ready_i && !redirect_i;
    held_item = out_o;
  endtask

  initial
  begin
    rst           = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = 32'd0;
    out_ready_i   = 1'b0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = 32'd0;
    foreach (sh_valid[i])
      sh_valid[i] = 1'b0;
    repeat (4)
    begin
      @(posedge clk);
      @(negedge clk);
      if (out_valid_o || mem_req_o)
        bus_error("output valid or memory request during reset");
    end
    rst = 1'b0;
    @(negedge clk);
    if (out_valid_o)
      data_error("out_valid_o high right after reset");
    while (items < 500 && idle <= 200)
    begin
      serve_memory();
      drive_decode();
      @(negedge clk);
    end
    if (idle > 200)
    begin
      timeouts++;
      $display("no instruction reached decode within 200 cycles");
    end
    $display("items %0d, data errors %0d, bus errors %0d, timeouts %0d",
             items, data_errors, bus_errors, timeouts);
    if (data_errors + bus_errors + timeouts == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
